// File: hdl/lsu_pkg.sv
package lsu_pkg;

    // data and address width
    localparam int XLEN = 32;

    // register index width
    localparam int REG_W = 5;

    // risc-v load/store access kinds
    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } mem_op_t;

    // align stage sequencing
    typedef enum logic [1:0] {
        IDLE,
        LOAD_OUT,
        STORE_AW_W,
        STORE_B
    } align_state_t;

endpackage

// File: hdl/mem_issue.sv
`timescale 1ns/1ns

module mem_issue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                         CLK,
    input  logic                         rst,

    input  logic                         req_valid,
    output logic                         req_ready,
    input  lsu_pkg::mem_op_t             req_op,
    input  logic [lsu_pkg::XLEN-1:0]     req_addr,
    input  logic [lsu_pkg::XLEN-1:0]     req_wdata,
    input  logic [lsu_pkg::REG_W-1:0]    req_rd,

    output logic [lsu_pkg::XLEN-1:0]     araddr,
    output logic                         arvalid,
    input  logic                         arready,

    input  logic                         queue_full,
    input  logic                         store_done,

    output logic                         push_en,
    output lsu_pkg::mem_op_t             push_op,
    output logic [lsu_pkg::XLEN-1:0]     push_addr,
    output logic [lsu_pkg::XLEN-1:0]     push_wdata,
    output logic [lsu_pkg::REG_W-1:0]    push_rd
);
    import lsu_pkg::*;

    logic live;
    logic store_busy;
    logic accept;
    logic req_is_store;

    // depth must index the queue with whole pointer bits
    if ((QUEUE_DEPTH < 2) || (QUEUE_DEPTH > 16) ||
        ((QUEUE_DEPTH & (QUEUE_DEPTH - 1)) != 0)) begin : g_depth_check
        $error("mem_issue: QUEUE_DEPTH must be a power of two from 2 to 16");
    end

    assign req_is_store = (req_op == SB) || (req_op == SH) || (req_op == SW);

    // one AR slot, queue room, and no read-modify-write in progress
    assign req_ready = live && !arvalid && !queue_full && !store_busy;
    assign accept    = req_valid && req_ready;

    // details go to the queue in the accept cycle
    assign push_en    = accept;
    assign push_op    = req_op;
    assign push_addr  = req_addr;
    assign push_wdata = req_wdata;
    assign push_rd    = req_rd;

    always_ff @(posedge CLK) begin
        if (rst) begin
            live       <= 1'b0;
            arvalid    <= 1'b0;
            store_busy <= 1'b0;
        end
        else begin
            live <= 1'b1;
            if (accept) begin
                arvalid <= 1'b1;
            end
            else if (arready) begin
                arvalid <= 1'b0;
            end
            if (accept && req_is_store) begin
                store_busy <= 1'b1;
            end
            else if (store_done) begin
                store_busy <= 1'b0;
            end
        end
    end

    // word aligned read address
    always_ff @(posedge CLK) begin
        if (accept) begin
            araddr <= {req_addr[XLEN-1:2], 2'b00};
        end
    end

endmodule

// File: hdl/op_queue.sv
`timescale 1ns/1ns

module op_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                         CLK,
    input  logic                         rst,

    input  logic                         push_en,
    input  lsu_pkg::mem_op_t             push_op,
    input  logic [lsu_pkg::XLEN-1:0]     push_addr,
    input  logic [lsu_pkg::XLEN-1:0]     push_wdata,
    input  logic [lsu_pkg::REG_W-1:0]    push_rd,
    input  logic                         pop,

    output logic                         full,
    output logic                         head_valid,
    output lsu_pkg::mem_op_t             head_op,
    output logic [lsu_pkg::XLEN-1:0]     head_addr,
    output logic [lsu_pkg::XLEN-1:0]     head_wdata,
    output logic [lsu_pkg::REG_W-1:0]    head_rd
);
    import lsu_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    mem_op_t            op_mem    [QUEUE_DEPTH];
    logic [XLEN-1:0]    addr_mem  [QUEUE_DEPTH];
    logic [XLEN-1:0]    wdata_mem [QUEUE_DEPTH];
    logic [REG_W-1:0]   rd_mem    [QUEUE_DEPTH];

    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;

    assign full       = (count == (PTR_W + 1)'(QUEUE_DEPTH));
    assign head_valid = (count != '0);

    assign head_op    = op_mem[rd_ptr];
    assign head_addr  = addr_mem[rd_ptr];
    assign head_wdata = wdata_mem[rd_ptr];
    assign head_rd    = rd_mem[rd_ptr];

    always_ff @(posedge CLK) begin
        if (push_en) begin
            op_mem[wr_ptr]    <= push_op;
            addr_mem[wr_ptr]  <= push_addr;
            wdata_mem[wr_ptr] <= push_wdata;
            rd_mem[wr_ptr]    <= push_rd;
        end
    end

    // pointers wrap on their own width
    always_ff @(posedge CLK) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (push_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (PTR_W + 1)'(push_en) - (PTR_W + 1)'(pop);
        end
    end

endmodule

// File: hdl/mem_align.sv
`timescale 1ns/1ns

module mem_align (
    input  logic                           CLK,
    input  logic                           rst,

    input  logic                           head_valid,
    input  lsu_pkg::mem_op_t               head_op,
    input  logic [lsu_pkg::XLEN-1:0]       head_addr,
    input  logic [lsu_pkg::XLEN-1:0]       head_wdata,
    input  logic [lsu_pkg::REG_W-1:0]      head_rd,
    output logic                           pop,

    input  logic [lsu_pkg::XLEN-1:0]       rdata,
    input  logic                           rvalid,
    output logic                           rready,

    output logic [lsu_pkg::XLEN-1:0]       awaddr,
    output logic                           awvalid,
    input  logic                           awready,
    output logic [lsu_pkg::XLEN-1:0]       wdata,
    output logic [lsu_pkg::XLEN/8-1:0]     wstrb,
    output logic                           wvalid,
    input  logic                           wready,
    input  logic                           bvalid,
    output logic                           bready,
    output logic                           store_done,

    output logic                           res_valid,
    input  logic                           res_ready,
    output logic [lsu_pkg::REG_W-1:0]      res_rd,
    output logic [lsu_pkg::XLEN-1:0]       res_data
);
    import lsu_pkg::*;

    align_state_t state;
    logic aw_pend;
    logic w_pend;
    logic r_fire;
    logic head_is_store;

    // byte or halfword out of the fetched word, then extended
    function automatic logic [XLEN-1:0] load_extract(
        input mem_op_t         op,
        input logic [1:0]      off,
        input logic [XLEN-1:0] word
    );
        logic [XLEN-1:0] lane;
        lane = word >> {off, 3'b000};
        case (op)
            LB:      return {{(XLEN - 8){lane[7]}}, lane[7:0]};
            LBU:     return {{(XLEN - 8){1'b0}}, lane[7:0]};
            LH:      return (off == 2'd3) ? word : {{(XLEN - 16){lane[15]}}, lane[15:0]};
            LHU:     return (off == 2'd3) ? word : {{(XLEN - 16){1'b0}}, lane[15:0]};
            default: return word;
        endcase
    endfunction

    // new lanes into the old word; crossing accesses take the source whole
    function automatic logic [XLEN-1:0] store_merge(
        input mem_op_t         op,
        input logic [1:0]      off,
        input logic [XLEN-1:0] dst,
        input logic [XLEN-1:0] src
    );
        logic [XLEN-1:0] mask;
        logic [XLEN-1:0] lane;
        lane = src << {off, 3'b000};
        case (op)
            SB:      mask = {{(XLEN - 8){1'b0}}, 8'hff} << {off, 3'b000};
            SH:      mask = {{(XLEN - 16){1'b0}}, 16'hffff} << {off, 3'b000};
            default: mask = '1;
        endcase
        if ((op == SH) && (off == 2'd3)) begin
            return src;
        end
        if (mask == '1) begin
            return src;
        end
        return (dst & ~mask) | (lane & mask);
    endfunction

    assign head_is_store = (head_op == SB) || (head_op == SH) || (head_op == SW);

    // take R only with a head entry and no result waiting
    assign rready     = (state == IDLE) && head_valid;
    assign r_fire     = rvalid && rready;
    assign pop        = r_fire;

    assign res_valid  = (state == LOAD_OUT);
    assign awvalid    = aw_pend;
    assign wvalid     = w_pend;
    assign wstrb      = '1;
    assign bready     = (state == STORE_B);
    assign store_done = bready && bvalid;

    always_ff @(posedge CLK) begin
        if (rst) begin
            state   <= IDLE;
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
        end
        else begin
            case (state)
                IDLE: begin
                    if (r_fire) begin
                        if (head_is_store) begin
                            state   <= STORE_AW_W;
                            aw_pend <= 1'b1;
                            w_pend  <= 1'b1;
                        end
                        else begin
                            state <= LOAD_OUT;
                        end
                    end
                end
                LOAD_OUT: begin
                    if (res_ready) begin
                        state <= IDLE;
                    end
                end
                STORE_AW_W: begin
                    if (awready) begin
                        aw_pend <= 1'b0;
                    end
                    if (wready) begin
                        w_pend <= 1'b0;
                    end
                    // AW and W may finish in either order
                    if ((!aw_pend || awready) && (!w_pend || wready)) begin
                        state <= STORE_B;
                    end
                end
                STORE_B: begin
                    if (bvalid) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (r_fire) begin
            res_data <= load_extract(head_op, head_addr[1:0], rdata);
            res_rd   <= head_rd;
            wdata    <= store_merge(head_op, head_addr[1:0], rdata, head_wdata);
            awaddr   <= {head_addr[XLEN-1:2], 2'b00};
        end
    end

endmodule

// File: hdl/lsu_top.sv
`timescale 1ns/1ns

module lsu_top #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                           CLK,
    input  logic                           rst,

    input  logic                           req_valid,
    output logic                           req_ready,
    input  lsu_pkg::mem_op_t               req_op,
    input  logic [lsu_pkg::XLEN-1:0]       req_addr,
    input  logic [lsu_pkg::XLEN-1:0]       req_wdata,
    input  logic [lsu_pkg::REG_W-1:0]      req_rd,

    output logic [lsu_pkg::XLEN-1:0]       araddr,
    output logic                           arvalid,
    input  logic                           arready,
    input  logic [lsu_pkg::XLEN-1:0]       rdata,
    input  logic [1:0]                     rresp,
    input  logic                           rvalid,
    output logic                           rready,

    output logic [lsu_pkg::XLEN-1:0]       awaddr,
    output logic                           awvalid,
    input  logic                           awready,
    output logic [lsu_pkg::XLEN-1:0]       wdata,
    output logic [lsu_pkg::XLEN/8-1:0]     wstrb,
    output logic                           wvalid,
    input  logic                           wready,
    input  logic [1:0]                     bresp,
    input  logic                           bvalid,
    output logic                           bready,

    output logic                           res_valid,
    input  logic                           res_ready,
    output logic [lsu_pkg::REG_W-1:0]      res_rd,
    output logic [lsu_pkg::XLEN-1:0]       res_data
);
    import lsu_pkg::*;

    logic               push_en;
    mem_op_t            push_op;
    logic [XLEN-1:0]    push_addr;
    logic [XLEN-1:0]    push_wdata;
    logic [REG_W-1:0]   push_rd;
    logic               queue_full;

    logic               head_valid;
    mem_op_t            head_op;
    logic [XLEN-1:0]    head_addr;
    logic [XLEN-1:0]    head_wdata;
    logic [REG_W-1:0]   head_rd;
    logic               pop;
    logic               store_done;

    mem_issue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) issue0 (
        .CLK        (CLK),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_op     (req_op),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_rd     (req_rd),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .queue_full (queue_full),
        .store_done (store_done),
        .push_en    (push_en),
        .push_op    (push_op),
        .push_addr  (push_addr),
        .push_wdata (push_wdata),
        .push_rd    (push_rd)
    );

    op_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) queue0 (
        .CLK        (CLK),
        .rst        (rst),
        .push_en    (push_en),
        .push_op    (push_op),
        .push_addr  (push_addr),
        .push_wdata (push_wdata),
        .push_rd    (push_rd),
        .pop        (pop),
        .full       (queue_full),
        .head_valid (head_valid),
        .head_op    (head_op),
        .head_addr  (head_addr),
        .head_wdata (head_wdata),
        .head_rd    (head_rd)
    );

    // response codes are not checked, rresp and bresp end here
    mem_align align0 (
        .CLK        (CLK),
        .rst        (rst),
        .head_valid (head_valid),
        .head_op    (head_op),
        .head_addr  (head_addr),
        .head_wdata (head_wdata),
        .head_rd    (head_rd),
        .pop        (pop),
        .rdata      (rdata),
        .rvalid     (rvalid),
        .rready     (rready),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bvalid     (bvalid),
        .bready     (bready),
        .store_done (store_done),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res_rd     (res_rd),
        .res_data   (res_data)
    );

endmodule

// File: test/axil_mem_model.sv
`timescale 1ns/1ns

module axil_mem_model #(
    parameter int SEED = 60
) (
    input  logic                         CLK,

    input  logic [lsu_pkg::XLEN-1:0]     araddr,
    input  logic                         arvalid,
    output logic                         arready,
    output logic [lsu_pkg::XLEN-1:0]     rdata,
    output logic [1:0]                   rresp,
    output logic                         rvalid,
    input  logic                         rready,

    input  logic [lsu_pkg::XLEN-1:0]     awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [lsu_pkg::XLEN-1:0]     wdata,
    input  logic [lsu_pkg::XLEN/8-1:0]   wstrb,
    input  logic                         wvalid,
    output logic                         wready,
    output logic [1:0]                   bresp,
    output logic                         bvalid,
    input  logic                         bready
);
    import lsu_pkg::*;

    // 256 words, byte address bits 9:2
    logic [XLEN-1:0]    mem [256];
    logic [XLEN-1:0]    read_q [$];
    logic [XLEN-1:0]    wr_addr;
    logic [XLEN-1:0]    wr_data;
    logic               aw_have;
    logic               w_have;
    logic               b_pend;
    logic               ar_take;
    logic               r_take;
    logic               aw_take;
    logic               w_take;
    logic               b_take;
    logic [31:0]        rng;
    int                 ar_cnt;
    int                 r_cnt;
    int                 aw_cnt;
    int                 w_cnt;
    int                 b_cnt;

    // xorshift step, 0 to 3 cycles out
    task automatic pick_delay(output int d);
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        d = int'(rng[1:0]);
    endtask

    initial begin
        rng     = 32'(SEED);
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rresp   = 2'b00;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        bresp   = 2'b00;
        ar_take = 1'b0;
        r_take  = 1'b0;
        aw_take = 1'b0;
        w_take  = 1'b0;
        b_take  = 1'b0;
        aw_have = 1'b0;
        w_have  = 1'b0;
        b_pend  = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        pick_delay(ar_cnt);
        pick_delay(r_cnt);
        pick_delay(aw_cnt);
        pick_delay(w_cnt);
        b_cnt = 0;
    end

    // valids from the DUT hold from here to the next rising edge,
    // so a transfer is known one half cycle ahead
    always @(negedge CLK) begin
        // R before AR, data only for reads already taken
        if (r_take) begin
            rvalid = 1'b0;
            r_take = 1'b0;
            void'(read_q.pop_front());
            pick_delay(r_cnt);
        end
        if (!rvalid && (read_q.size() != 0)) begin
            if (r_cnt == 0) begin
                rvalid = 1'b1;
                rdata  = read_q[0];
            end
            else begin
                r_cnt = r_cnt - 1;
            end
        end
        if (rvalid && rready) begin
            r_take = 1'b1;
        end

        if (ar_take) begin
            arready = 1'b0;
            ar_take = 1'b0;
            pick_delay(ar_cnt);
        end
        if (arvalid && !arready) begin
            if (ar_cnt == 0) begin
                arready = 1'b1;
            end
            else begin
                ar_cnt = ar_cnt - 1;
            end
        end
        if (arvalid && arready) begin
            ar_take = 1'b1;
            read_q.push_back(mem[araddr[9:2]]);
        end

        // B before AW/W so the response trails the write
        if (b_take) begin
            bvalid = 1'b0;
            b_take = 1'b0;
        end
        if (b_pend && !bvalid) begin
            if (b_cnt == 0) begin
                bvalid = 1'b1;
                b_pend = 1'b0;
            end
            else begin
                b_cnt = b_cnt - 1;
            end
        end
        if (bvalid && bready) begin
            b_take = 1'b1;
        end

        if (aw_take) begin
            awready = 1'b0;
            aw_take = 1'b0;
            pick_delay(aw_cnt);
        end
        if (awvalid && !awready) begin
            if (aw_cnt == 0) begin
                awready = 1'b1;
            end
            else begin
                aw_cnt = aw_cnt - 1;
            end
        end
        if (awvalid && awready) begin
            aw_take = 1'b1;
            aw_have = 1'b1;
            wr_addr = awaddr;
        end

        if (w_take) begin
            wready = 1'b0;
            w_take = 1'b0;
            pick_delay(w_cnt);
        end
        if (wvalid && !wready) begin
            if (w_cnt == 0) begin
                wready = 1'b1;
            end
            else begin
                w_cnt = w_cnt - 1;
            end
        end
        if (wvalid && wready) begin
            w_take = 1'b1;
            w_have = 1'b1;
            wr_data = wdata;
        end

        if (aw_have && w_have) begin
            mem[wr_addr[9:2]] = wr_data;
            aw_have = 1'b0;
            w_have  = 1'b0;
            b_pend  = 1'b1;
            pick_delay(b_cnt);
        end
    end

endmodule

// File: test/lsu_tb.sv
`timescale 1ns/1ns

module lsu_tb;
    import lsu_pkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int MEM_WORDS   = 256;
    localparam int CYCLE_NS    = 8;
    // word, byte, halfword, sub-word store and random tests
    localparam int N_REQS      = 4 + 16 + 16 + 16 + 200;
    localparam int WATCHDOG_NS = (N_REQS * 200 + 8) * CYCLE_NS;

    logic               CLK;
    logic               rst;
    logic               req_valid;
    logic               req_ready;
    mem_op_t            req_op;
    logic [XLEN-1:0]    req_addr;
    logic [XLEN-1:0]    req_wdata;
    logic [REG_W-1:0]   req_rd;
    logic [XLEN-1:0]    araddr;
    logic               arvalid;
    logic               arready;
    logic [XLEN-1:0]    rdata;
    logic [1:0]         rresp;
    logic               rvalid;
    logic               rready;
    logic [XLEN-1:0]    awaddr;
    logic               awvalid;
    logic               awready;
    logic [XLEN-1:0]    wdata;
    logic [XLEN/8-1:0]  wstrb;
    logic               wvalid;
    logic               wready;
    logic [1:0]         bresp;
    logic               bvalid;
    logic               bready;
    logic               res_valid;
    logic               res_ready;
    logic [REG_W-1:0]   res_rd;
    logic [XLEN-1:0]    res_data;

    logic [XLEN-1:0]    shadow [MEM_WORDS];
    logic [XLEN-1:0]    exp_data [$];
    logic [REG_W-1:0]   exp_rd [$];
    logic [31:0]        stim_rng;
    logic [31:0]        bp_rng;
    logic               bp_on;
    int                 errors;
    int                 checks;
    int                 tests;
    int                 max_in_flight;

    lsu_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) dut0 (.*);

    axil_mem_model #(
        .SEED (60)
    ) mem0 (.*);

    initial CLK = 1'b0;
    always #(CYCLE_NS / 2) CLK = ~CLK;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // expected load value; stores update the shadow words
    function automatic logic [XLEN-1:0] ref_access(
        input mem_op_t         op,
        input logic [XLEN-1:0] addr,
        input logic [XLEN-1:0] src
    );
        logic [XLEN-1:0] word;
        logic [4:0]      sh;
        logic [7:0]      b;
        logic [15:0]     h;
        word = shadow[addr[9:2]];
        sh = {addr[1:0], 3'b000};
        b = word[sh +: 8];
        case (op)
            LB:  return {{(XLEN - 8){b[7]}}, b};
            LBU: return {{(XLEN - 8){1'b0}}, b};
            LH, LHU: begin
                // crosses into the next word
                if (addr[1:0] == 2'd3) begin
                    return word;
                end
                h = word[sh +: 16];
                if (op == LH) begin
                    return {{(XLEN - 16){h[15]}}, h};
                end
                return {{(XLEN - 16){1'b0}}, h};
            end
            LW:  return word;
            SB:  word[sh +: 8] = src[7:0];
            SH: begin
                if (addr[1:0] == 2'd3) begin
                    word = src;
                end
                else begin
                    word[sh +: 16] = src[15:0];
                end
            end
            default: word = src;
        endcase
        shadow[addr[9:2]] = word;
        return '0;
    endfunction

    task automatic seed_word(input int idx, input logic [XLEN-1:0] value);
        shadow[idx[7:0]] = value;
        mem0.mem[idx[7:0]] = value;
    endtask

    task automatic check_data(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR @ %0t ns: %s data %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic check_rd(input logic [REG_W-1:0] got, input logic [REG_W-1:0] exp,
                            input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR @ %0t ns: %s rd %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_strb(input logic [XLEN/8-1:0] got, input logic [XLEN/8-1:0] exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR @ %0t ns: %s wstrb %b, expected %b", $time, what, got, exp);
        end
    endtask

    // starts and ends on a falling edge
    task automatic issue(input mem_op_t op, input logic [XLEN-1:0] addr,
                         input logic [XLEN-1:0] src, input logic [REG_W-1:0] rd);
        logic [XLEN-1:0] expect_val;
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_wdata = src;
        req_rd    = rd;
        while (!req_ready) begin
            @(negedge CLK);
        end
        expect_val = ref_access(op, addr, src);
        if ((op != SB) && (op != SH) && (op != SW)) begin
            exp_data.push_back(expect_val);
            exp_rd.push_back(rd);
            if (exp_rd.size() > max_in_flight) begin
                max_in_flight = exp_rd.size();
            end
        end
        @(negedge CLK);
        req_valid = 1'b0;
    endtask

    // all loads answered and the last store written back
    task automatic drain();
        while ((exp_rd.size() != 0) || !req_ready) begin
            @(negedge CLK);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - errs_before);
    endtask

    // a result offered here transfers at the next rising edge
    always @(negedge CLK) begin
        bp_rng = xorshift32(bp_rng);
        res_ready = bp_on ? (bp_rng[4] | bp_rng[7]) : 1'b1;
        if (res_valid && res_ready) begin
            if (exp_rd.size() == 0) begin
                errors++;
                $display("a result for rd %0d arrived with no load outstanding", res_rd);
            end
            else begin
                check_rd(res_rd, exp_rd.pop_front(), "load");
                check_data(res_data, exp_data.pop_front(), "load");
            end
        end
    end

    // full-word write back needs every strobe set
    always @(negedge CLK) begin
        if (wvalid) begin
            check_strb(wstrb, {(XLEN / 8){1'b1}}, "store");
        end
    end

    initial begin
        int               errs;
        logic [31:0]      r;
        logic [XLEN-1:0]  a;
        rst       = 1'b1;
        req_valid = 1'b0;
        req_op    = LW;
        req_addr  = '0;
        req_wdata = '0;
        req_rd    = '0;
        res_ready = 1'b0;
        bp_on     = 1'b0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        max_in_flight = 0;
        stim_rng  = 32'd60;
        bp_rng    = 32'd60;
        for (int i = 0; i < MEM_WORDS; i++) begin
            seed_word(i, xorshift32(32'(i) * 32'h9e37_79b9 + 32'd1));
        end
        // high-bit bytes mixed with low ones at 0x100 and 0x104
        seed_word(32'h40, 32'hf081_7fc3);
        seed_word(32'h41, 32'h128e_ff05);
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        rst = 1'b0;
        @(negedge CLK);

        errs = errors;
        issue(SW, 32'h200, 32'hdead_beef, 5'd0);
        issue(LW, 32'h200, '0, 5'd7);
        issue(SW, 32'h204, 32'h0123_4567, 5'd0);
        issue(LW, 32'h204, '0, 5'd12);
        drain();
        report_test("word store then word load", errs);

        errs = errors;
        for (int w = 0; w < 2; w++) begin
            for (int off = 0; off < 4; off++) begin
                a = 32'h100 + 32'(4 * w + off);
                issue(LB, a, '0, 5'(off + 1));
                issue(LBU, a, '0, 5'(off + 9));
            end
        end
        drain();
        report_test("byte loads", errs);

        errs = errors;
        for (int w = 0; w < 2; w++) begin
            for (int off = 0; off < 4; off++) begin
                a = 32'h100 + 32'(4 * w + off);
                issue(LH, a, '0, 5'(off + 17));
                issue(LHU, a, '0, 5'(off + 25));
            end
        end
        drain();
        report_test("halfword loads", errs);

        errs = errors;
        for (int off = 0; off < 4; off++) begin
            a = 32'h180 + 32'(off);
            stim_rng = xorshift32(stim_rng);
            issue(SB, a, stim_rng, 5'd0);
            issue(LW, 32'h180, '0, 5'(off + 3));
            stim_rng = xorshift32(stim_rng);
            issue(SH, a, stim_rng, 5'd0);
            issue(LW, 32'h180, '0, 5'(off + 20));
        end
        drain();
        report_test("sub-word stores", errs);

        // small window so stores and loads hit the same words
        errs = errors;
        bp_on = 1'b1;
        max_in_flight = 0;
        for (int n = 0; n < 200; n++) begin
            stim_rng = xorshift32(stim_rng);
            r = stim_rng;
            stim_rng = xorshift32(stim_rng);
            issue(mem_op_t'(r[2:0]), 32'h300 + {26'd0, r[8:3]}, stim_rng, r[13:9]);
        end
        drain();
        bp_on = 1'b0;
        if (max_in_flight < 2) begin
            errors++;
            $display("never more than one load in flight during the random mix");
        end
        report_test("random mix with back-pressure", errs);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end
        else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: build.f
hdl/lsu_pkg.sv
hdl/mem_issue.sv
hdl/op_queue.sv
hdl/mem_align.sv
hdl/lsu_top.sv
test/axil_mem_model.sv
test/lsu_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 --top-module lsu_tb -Mdir obj_dir -f build.f; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vlsu_tb)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1
